// File: iccm_pkg.sv
//********************
// Widths, access size and request types shared by all ICCM modules
// Pulled in by a wildcard import in each module header
//********************
package iccm_pkg;

   localparam int ICCM_DATA_W = 32;                        // Data bits per word
   localparam int ICCM_WORD_W = 39;                        // Data plus check bits
   localparam int ICCM_ECC_W  = ICCM_WORD_W - ICCM_DATA_W; // Check bits only

   //********************
   // Stored words
   //********************

   // One bank word, check bits above the data
   typedef struct packed {
      logic [ICCM_ECC_W-1:0]  ecc;
      logic [ICCM_DATA_W-1:0] data;
   } iccm_word_t;

   // Two stored words as they sit on the two bank legs
   typedef struct packed {
      iccm_word_t odd;    // Odd-word leg
      iccm_word_t even;   // Even-word leg
   } iccm_dword_t;

   //********************
   // Access size
   //********************

   // Only SIZE_DWORD changes the address increment and the write width
   typedef enum logic [1:0] {
      SIZE_BYTE  = 2'b00,
      SIZE_HALF  = 2'b01,
      SIZE_WORD  = 2'b10,
      SIZE_DWORD = 2'b11
   } iccm_size_e;

   //********************
   // Request and correction controls
   //********************

   // Level strobes, sampled on every clock
   typedef struct packed {
      logic        rden;
      logic        wren;
      iccm_size_e  size;
      iccm_dword_t wr_data;
   } iccm_req_t;

   typedef struct packed {
      logic correct_ecc;        // Correction cycle for the current address
      logic correction_state;   // A correction is in progress
   } iccm_fix_t;

endpackage

// File: iccm_bank_decode.sv
//********************
// Bank decode for the ICCM, purely combinational
// Maps one request onto per-bank enables, row indexes and write words
//********************
module iccm_bank_decode
   import iccm_pkg::*;
#(
   parameter  int ICCM_BITS      = 16,
   parameter  int ICCM_NUM_BANKS = 4,
   localparam int BANK_BITS      = $clog2(ICCM_NUM_BANKS),
   localparam int BANK_HI        = BANK_BITS + 1,
   localparam int INDEX_LO       = BANK_HI + 1,
   localparam int INDEX_W        = ICCM_BITS - INDEX_LO
) (
   input  iccm_req_t                              req,
   input  logic [ICCM_BITS-1:1]                   rw_addr,
   output logic [ICCM_NUM_BANKS-1:0]              bank_en,
   output logic [ICCM_NUM_BANKS-1:0]              bank_we,
   output logic [ICCM_NUM_BANKS-1:0][INDEX_W-1:0] bank_index,
   output iccm_word_t [ICCM_NUM_BANKS-1:0]        bank_wdata
);

   logic                      dword;
   logic [ICCM_BITS-1:1]      addr_inc;   // Halfword address of the second leg
   logic [ICCM_NUM_BANKS-1:0] hit_lo;
   logic [ICCM_NUM_BANKS-1:0] hit_hi;

   // Two halfwords for a doubleword, one for anything else
   assign dword    = (req.size == SIZE_DWORD);
   assign addr_inc = rw_addr + {{(ICCM_BITS-3){1'b0}}, dword, ~dword};

   //********************
   // Per-bank decode
   //********************
   for (genvar i = 0; i < ICCM_NUM_BANKS; i++) begin : g_bank
      assign hit_lo[i] = (rw_addr[BANK_HI:2] == BANK_BITS'(i));
      assign hit_hi[i] = (addr_inc[BANK_HI:2] == BANK_BITS'(i));

      assign bank_we[i] = req.wren & (hit_lo[i] | hit_hi[i]);
      assign bank_en[i] = (req.wren | req.rden) & (hit_lo[i] | hit_hi[i]);

      // Writes always index from rw_addr
      // Reads follow whichever address lands in this bank
      assign bank_index[i] = (req.wren | ~hit_hi[i]) ? rw_addr[ICCM_BITS-1:INDEX_LO]
                                                     : addr_inc[ICCM_BITS-1:INDEX_LO];

      if (i % 2 == 0) begin : g_even
         assign bank_wdata[i] = req.wr_data.even;   // Lower word to even banks
      end else begin : g_odd
         assign bank_wdata[i] = req.wr_data.odd;    // Upper word to odd banks
      end
   end

endmodule

// File: iccm_bank_ram.sv
//********************
// Behavioural single-port bank of 39-bit words, one cycle read latency
//********************
module iccm_bank_ram
   import iccm_pkg::*;
#(
   parameter  int DEPTH  = 4096,
   localparam int ADDR_W = $clog2(DEPTH)
) (
   input  logic              clk,
   input  logic              en,
   input  logic              we,
   input  logic [ADDR_W-1:0] index,
   input  iccm_word_t        wdata,
   output iccm_word_t        dout
);

   iccm_word_t mem [DEPTH];

   // Write and read share the one port
   always_ff @(posedge clk) begin
      if (en) begin
         if (we) begin
            mem[index] <= wdata;
         end else begin
            dout <= mem[index];   // Held until the next read
         end
      end
   end

endmodule

// File: iccm_redundancy.sv
//********************
// Two redundant rows that stand in for faulty ICCM words
// Loaded by correction cycles, kept current by writes, swapped in on reads
//********************
module iccm_redundancy
   import iccm_pkg::*;
#(
   parameter int ICCM_BITS      = 16,
   parameter int ICCM_NUM_BANKS = 4
) (
   input  logic                            clk,
   input  logic                            reset,
   input  iccm_req_t                       req,
   input  iccm_fix_t                       fix,
   input  logic [ICCM_BITS-1:1]            rw_addr,
   input  iccm_word_t [ICCM_NUM_BANKS-1:0] bank_dout,
   output iccm_word_t [ICCM_NUM_BANKS-1:0] bank_dout_fn
);

   localparam int BANK_BITS = $clog2(ICCM_NUM_BANKS);
   localparam int BANK_HI   = BANK_BITS + 1;

   logic                 dword;
   logic [ICCM_BITS-1:1] addr_inc;

   // Row storage
   logic [1:0][ICCM_BITS-1:2] red_addr;   // Word address held by each row
   logic [1:0]                red_valid;
   iccm_word_t [1:0]          red_data;
   logic                      red_lru;    // Row to replace next

   logic [1:0]                     row_load;   // Correction fills this row
   logic [1:0]                     row_upd;    // Write hits this row
   logic [1:0]                     row_hit;    // Read address hits this row
   iccm_word_t [1:0]               row_din;
   logic [1:0][ICCM_NUM_BANKS-1:0] sel;
   logic [1:0][ICCM_NUM_BANKS-1:0] sel_q;
   logic                           lru_upd;
   logic                           lru_din;

   assign dword    = (req.size == SIZE_DWORD);
   assign addr_inc = rw_addr + {{(ICCM_BITS-3){1'b0}}, dword, ~dword};

   //********************
   // Row match and update
   //********************
   for (genvar r = 0; r < 2; r++) begin : g_row
      logic odd_sel;   // Row covers the odd word of this write

      assign row_load[r] = fix.correct_ecc & (red_lru == 1'(r));

      // Same doubleword, and same word unless both words are written
      assign row_upd[r] = red_valid[r] & req.wren
                        & (rw_addr[ICCM_BITS-1:3] == red_addr[r][ICCM_BITS-1:3])
                        & ((rw_addr[2] == red_addr[r][2]) | dword);

      assign odd_sel    = red_addr[r][2] & (rw_addr[2] | dword);
      assign row_din[r] = (row_load[r] | ~odd_sel) ? req.wr_data.even : req.wr_data.odd;

      for (genvar i = 0; i < ICCM_NUM_BANKS; i++) begin : g_sel
         assign sel[r][i] = red_valid[r]
            & (((rw_addr[ICCM_BITS-1:2] == red_addr[r])
                & (rw_addr[BANK_HI:2] == BANK_BITS'(i)))
             | ((addr_inc[ICCM_BITS-1:2] == red_addr[r])
                & (addr_inc[BANK_HI:2] == BANK_BITS'(i))));
      end

      assign row_hit[r] = |sel[r];
   end

   // Hits only move the LRU while a correction is running
   assign lru_upd = fix.correct_ecc | ((|row_hit) & req.rden & fix.correction_state);
   assign lru_din = fix.correct_ecc ? ~red_lru : row_hit[0];

   always_ff @(posedge clk) begin
      if (reset) begin
         red_valid <= '0;
         red_lru   <= 1'b0;
         sel_q     <= '0;
      end else begin
         red_valid <= red_valid | row_load;
         sel_q     <= sel;   // Lines up with the bank read data
         if (lru_upd) begin
            red_lru <= lru_din;
         end
      end
   end

   always_ff @(posedge clk) begin
      for (int r = 0; r < 2; r++) begin
         if (row_load[r]) begin
            red_addr[r] <= rw_addr[ICCM_BITS-1:2];
         end
         if (row_load[r] | row_upd[r]) begin
            red_data[r] <= row_din[r];
         end
      end
   end

   //********************
   // Read substitution
   //********************
   for (genvar i = 0; i < ICCM_NUM_BANKS; i++) begin : g_fn
      assign bank_dout_fn[i] = sel_q[1][i] ? red_data[1] :
                               sel_q[0][i] ? red_data[0] : bank_dout[i];
   end

endmodule

// File: iccm_read_align.sv
//********************
// Picks the two bank words of a read and aligns them to the halfword address
//********************
module iccm_read_align
   import iccm_pkg::*;
#(
   parameter int ICCM_BITS      = 16,
   parameter int ICCM_NUM_BANKS = 4
) (
   input  logic                            clk,
   input  logic                            reset,
   input  logic [ICCM_BITS-1:1]            rw_addr,
   input  iccm_size_e                      size,
   input  iccm_word_t [ICCM_NUM_BANKS-1:0] bank_dout_fn,
   output logic [63:0]                     rd_data,
   output iccm_dword_t                     rd_data_ecc
);

   localparam int BANK_BITS = $clog2(ICCM_NUM_BANKS);
   localparam int BANK_HI   = BANK_BITS + 1;

   logic                       dword;
   logic [ICCM_BITS-1:1]       addr_inc;
   logic [BANK_HI:1]           lo_q;   // Address bank and halfword bit
   logic [BANK_HI:2]           hi_q;   // Bank of the incremented address
   iccm_word_t                 lo_word;
   iccm_word_t                 hi_word;
   logic [2*ICCM_DATA_W-1:0]   rd_pre;

   assign dword    = (size == SIZE_DWORD);
   assign addr_inc = rw_addr + {{(ICCM_BITS-3){1'b0}}, dword, ~dword};

   // Captured alongside the RAM read
   always_ff @(posedge clk) begin
      if (reset) begin
         lo_q <= '0;
         hi_q <= '0;
      end else begin
         lo_q <= rw_addr[BANK_HI:1];
         hi_q <= addr_inc[BANK_HI:2];
      end
   end

   assign lo_word = bank_dout_fn[lo_q[BANK_HI:2]];
   assign hi_word = bank_dout_fn[hi_q];

   // Raw words with check bits, never shifted
   assign rd_data_ecc.odd  = hi_word;
   assign rd_data_ecc.even = lo_word;

   // Odd halfword start drops the low halfword
   assign rd_pre  = {hi_word.data, lo_word.data};
   assign rd_data = lo_q[1] ? {16'b0, rd_pre[63:16]} : rd_pre;

endmodule

// File: iccm_mem.sv
//********************
// ICCM top level with banked RAMs, redundant rows and read alignment
//********************
module iccm_mem
   import iccm_pkg::*;
#(
   parameter int ICCM_BITS      = 16,
   parameter int ICCM_NUM_BANKS = 4
) (
   input  logic                 clk,
   input  logic                 reset,
   input  iccm_req_t            req,
   input  logic [ICCM_BITS-1:1] rw_addr,   // Halfword address
   input  iccm_fix_t            fix,
   output logic [63:0]          rd_data,
   output iccm_dword_t          rd_data_ecc
);

   localparam int BANK_BITS = $clog2(ICCM_NUM_BANKS);
   localparam int INDEX_W   = ICCM_BITS - BANK_BITS - 2;   // Row index per bank

   logic [ICCM_NUM_BANKS-1:0]              bank_en;
   logic [ICCM_NUM_BANKS-1:0]              bank_we;
   logic [ICCM_NUM_BANKS-1:0][INDEX_W-1:0] bank_index;
   iccm_word_t [ICCM_NUM_BANKS-1:0]        bank_wdata;
   iccm_word_t [ICCM_NUM_BANKS-1:0]        bank_dout;
   iccm_word_t [ICCM_NUM_BANKS-1:0]        bank_dout_fn;   // After row substitution

   iccm_bank_decode #(
      .ICCM_BITS      (ICCM_BITS),
      .ICCM_NUM_BANKS (ICCM_NUM_BANKS)
   ) decode_inst (
      .req        (req),
      .rw_addr    (rw_addr),
      .bank_en    (bank_en),
      .bank_we    (bank_we),
      .bank_index (bank_index),
      .bank_wdata (bank_wdata)
   );

   for (genvar i = 0; i < ICCM_NUM_BANKS; i++) begin : g_bank
      iccm_bank_ram #(
         .DEPTH (1 << INDEX_W)
      ) bank_inst (
         .clk   (clk),
         .en    (bank_en[i]),
         .we    (bank_we[i]),
         .index (bank_index[i]),
         .wdata (bank_wdata[i]),
         .dout  (bank_dout[i])
      );
   end

   iccm_redundancy #(
      .ICCM_BITS      (ICCM_BITS),
      .ICCM_NUM_BANKS (ICCM_NUM_BANKS)
   ) redundancy_inst (
      .clk          (clk),
      .reset        (reset),
      .req          (req),
      .fix          (fix),
      .rw_addr      (rw_addr),
      .bank_dout    (bank_dout),
      .bank_dout_fn (bank_dout_fn)
   );

   iccm_read_align #(
      .ICCM_BITS      (ICCM_BITS),
      .ICCM_NUM_BANKS (ICCM_NUM_BANKS)
   ) align_inst (
      .clk          (clk),
      .reset        (reset),
      .rw_addr      (rw_addr),
      .size         (req.size),
      .bank_dout_fn (bank_dout_fn),
      .rd_data      (rd_data),
      .rd_data_ecc  (rd_data_ecc)
   );

endmodule

// File: tb_clock_gen.sv
//********************
// Free-running testbench clock, starts low
//********************
module tb_clock_gen #(
   parameter int PERIOD = 8
) (
   output logic clk
);

   initial begin
      clk = 1'b0;
      forever #(PERIOD / 2) clk = ~clk;
   end

endmodule

// File: iccm_tb_tasks.svh
//********************
// Reference model, compare tasks and drive tasks for the ICCM testbench
// Included inside the testbench module after its signal declarations
//********************

//********************
// Reference model
//********************
iccm_word_t  ref_mem [int];     // Stored words by word address
int          ref_row_addr [2];
bit          ref_valid [2];
iccm_word_t  ref_row_data [2];
bit          ref_lru;           // Row taken by the next correction

// Read result due on the next falling edge
bit          pend_valid;
string       pend_what;
iccm_dword_t pend_ecc;
logic [63:0] pend_data;

function automatic iccm_word_t rand_word();
   logic [63:0] r;
   r = {$random(seed), $random(seed)};
   return r[ICCM_WORD_W-1:0];
endfunction

function automatic iccm_dword_t rand_dword();
   iccm_dword_t d;
   d.odd  = rand_word();
   d.even = rand_word();
   return d;
endfunction

// Halfword address of the second leg
function automatic int inc_hw(int hw, iccm_size_e size);
   return (hw + ((size == SIZE_DWORD) ? 2 : 1)) & ((1 << HW_W) - 1);
endfunction

function automatic iccm_word_t ref_word(int w);
   iccm_word_t res;
   if (ref_mem.exists(w)) begin
      res = ref_mem[w];
   end else begin
      res = 'x;
   end
   if (ref_valid[0] && ref_row_addr[0] == w) res = ref_row_data[0];
   if (ref_valid[1] && ref_row_addr[1] == w) res = ref_row_data[1];
   return res;
endfunction

function automatic void model_write(int hw, iccm_size_e size, iccm_dword_t data);
   int lo;
   int hi;
   lo = hw >> 1;
   hi = inc_hw(hw, size) >> 1;
   for (int r = 0; r < 2; r++) begin
      // Same doubleword, and same word unless both words are written
      if (ref_valid[r] && (lo >> 1) == (ref_row_addr[r] >> 1)
          && ((lo % 2) == (ref_row_addr[r] % 2) || size == SIZE_DWORD)) begin
         ref_row_data[r] = (ref_row_addr[r] % 2 == 1) ? data.odd : data.even;
      end
   end
   ref_mem[lo] = (lo % 2 == 1) ? data.odd : data.even;   // Odd words sit in odd banks
   ref_mem[hi] = (hi % 2 == 1) ? data.odd : data.even;
endfunction

function automatic void model_correct(int hw, iccm_word_t data);
   ref_row_addr[ref_lru] = hw >> 1;
   ref_row_data[ref_lru] = data;
   ref_valid[ref_lru]    = 1'b1;
   ref_lru               = ~ref_lru;
endfunction

// A read during a correction steers the LRU away from the row it hits
function automatic void model_hit(int lo, int hi);
   bit hit0;
   bit hit1;
   hit0 = ref_valid[0] && (ref_row_addr[0] == lo || ref_row_addr[0] == hi);
   hit1 = ref_valid[1] && (ref_row_addr[1] == lo || ref_row_addr[1] == hi);
   if (hit0 || hit1) begin
      ref_lru = hit0;
   end
endfunction

//********************
// Compare tasks
//********************
task automatic check_word(input string what, input iccm_dword_t exp, input iccm_dword_t act);
   if (act !== exp) begin
      err_count++;
      $display("Error at time %0t: %s rd_data_ecc expected %h got %h", $time, what, exp, act);
   end
endtask

task automatic check_data(input string what, input logic [63:0] exp, input logic [63:0] act);
   if (act !== exp) begin
      err_count++;
      $display("Error at time %0t: %s rd_data expected %h got %h", $time, what, exp, act);
   end
endtask

//********************
// Drive tasks
//********************

// Pending read result is checked on the falling edge before new inputs go out
task automatic next_cycle();
   @(negedge clk);
   if (pend_valid) begin
      check_word(pend_what, pend_ecc, rd_data_ecc);
      check_data(pend_what, pend_data, rd_data);
      pend_valid = 1'b0;
   end
endtask

task automatic do_write(input int hw, input iccm_size_e size, input iccm_dword_t data);
   next_cycle();
   req.rden    = 1'b0;
   req.wren    = 1'b1;
   req.size    = size;
   req.wr_data = data;
   rw_addr     = HW_W'(hw);
   fix         = '0;
   model_write(hw, size, data);
endtask

task automatic do_read(input int hw, input iccm_size_e size, input string what,
                       input bit in_correction = 1'b0);
   iccm_word_t  lo_w;
   iccm_word_t  hi_w;
   logic [63:0] pair;
   next_cycle();
   req.rden = 1'b1;
   req.wren = 1'b0;
   req.size = size;
   rw_addr  = HW_W'(hw);
   fix      = '0;
   fix.correction_state = in_correction;   // A row hit then moves the LRU
   lo_w = ref_word(hw >> 1);
   hi_w = ref_word(inc_hw(hw, size) >> 1);
   pend_ecc.odd  = hi_w;   // Second leg on top
   pend_ecc.even = lo_w;
   pair = {hi_w.data, lo_w.data};
   pend_data  = (hw % 2 == 1) ? {16'h0, pair[63:16]} : pair;
   pend_what  = what;
   pend_valid = 1'b1;
   if (in_correction) begin
      model_hit(hw >> 1, inc_hw(hw, size) >> 1);
   end
endtask

// Correction cycle that leaves the RAM untouched
task automatic do_correct(input int hw, input iccm_word_t data);
   next_cycle();
   req.rden             = 1'b0;
   req.wren             = 1'b0;
   req.size             = SIZE_WORD;
   req.wr_data.even     = data;
   req.wr_data.odd      = '0;
   rw_addr              = HW_W'(hw);
   fix.correct_ecc      = 1'b1;
   fix.correction_state = 1'b1;
   model_correct(hw, data);
endtask

task automatic do_idle();
   next_cycle();
   req.rden = 1'b0;
   req.wren = 1'b0;
   fix      = '0;
endtask

// File: iccm_mem_tb.sv
//********************
// Directed testbench for the ICCM with every read checked against a reference model
//********************
module iccm_mem_tb
   import iccm_pkg::*;
();

   localparam int CLK_PERIOD   = 8;
   localparam int RESET_CYCLES = 10;
   localparam int HW_W         = 15;   // Halfword address width
   localparam int NUM_BANKS    = 4;
   // Cycles of each test in run order
   localparam int TEST_CYCLES  = RESET_CYCLES + 5 + 10 + 4 + 5 + 16;
   localparam int MARGIN       = 200;

   logic        clk;
   logic        reset;
   iccm_req_t   req;
   logic [HW_W-1:0] rw_addr;
   iccm_fix_t   fix;
   logic [63:0] rd_data;
   iccm_dword_t rd_data_ecc;

   integer seed;
   int     err_count  = 0;
   int     pass_count = 0;
   int     fail_count = 0;

   `include "iccm_tb_tasks.svh"

   tb_clock_gen #(.PERIOD(CLK_PERIOD)) clock_inst (.clk(clk));

   iccm_mem iccm_mem_inst (
      .clk         (clk),
      .reset       (reset),
      .req         (req),
      .rw_addr     (rw_addr),
      .fix         (fix),
      .rd_data     (rd_data),
      .rd_data_ecc (rd_data_ecc)
   );

   function automatic int hw_addr(int row, int bank, int half);
      return ((row * NUM_BANKS + bank) * 2) + half;
   endfunction

   task automatic report_test(input string name, input int errs_before);
      if (err_count == errs_before) begin
         pass_count++;
         $display("PASS  %s", name);
      end else begin
         fail_count++;
         $display("FAIL  %s (%0d mismatches)", name, err_count - errs_before);
      end
   endtask

   //********************
   // Tests
   //********************
   task automatic test_dword_rw();
      int errs;
      errs = err_count;
      for (int b = 0; b < NUM_BANKS; b += 2) begin   // One write per bank pair
         do_write(hw_addr(10, b, 0), SIZE_DWORD, rand_dword());
      end
      for (int b = 0; b < NUM_BANKS; b += 2) begin
         do_read(hw_addr(10, b, 0), SIZE_DWORD, "dword read");
      end
      do_idle();
      report_test("doubleword write then read", errs);
   endtask

   task automatic test_word_banks();
      int errs;
      errs = err_count;
      for (int b = 0; b <= NUM_BANKS; b++) begin   // Last one lands in bank 0 of the next row
         do_write(hw_addr(20, b, 0), SIZE_WORD, rand_dword());
      end
      for (int b = 0; b < NUM_BANKS; b++) begin
         do_read(hw_addr(20, b, 0), SIZE_DWORD, "back to back read");
      end
      do_idle();
      report_test("word writes across banks", errs);
   endtask

   task automatic test_half_read();
      int errs;
      errs = err_count;
      do_read(hw_addr(20, 1, 1), SIZE_WORD, "odd halfword read");
      do_read(hw_addr(20, 3, 1), SIZE_WORD, "odd halfword wrap");
      do_read(hw_addr(10, 0, 1), SIZE_DWORD, "odd halfword dword");
      do_idle();
      report_test("halfword aligned read", errs);
   endtask

   task automatic test_correction();
      int          errs;
      iccm_dword_t d;
      errs = err_count;
      d = rand_dword();
      do_write(hw_addr(30, 0, 0), SIZE_DWORD, d);
      do_correct(hw_addr(30, 0, 0), ~d.even);   // Every bit differs from RAM
      do_read(hw_addr(30, 0, 0), SIZE_DWORD, "corrected word");
      do_read(hw_addr(30, 1, 0), SIZE_WORD, "neighbour word");
      do_idle();
      report_test("correction substitution", errs);
   endtask

   task automatic test_lru();
      int errs;
      int a;
      int b;
      int c;
      errs = err_count;
      a = hw_addr(40, 0, 0);
      b = hw_addr(40, 2, 0);
      c = hw_addr(41, 0, 0);
      do_write(a, SIZE_DWORD, rand_dword());
      do_write(b, SIZE_DWORD, rand_dword());
      do_write(c, SIZE_DWORD, rand_dword());
      do_correct(a, rand_word());
      do_correct(b, rand_word());
      do_correct(c, rand_word());   // Evicts the row holding a
      do_read(a, SIZE_WORD, "evicted word");
      do_read(b, SIZE_WORD, "row word b");
      do_read(c, SIZE_WORD, "row word c");
      do_write(b, SIZE_DWORD, rand_dword());
      do_read(b, SIZE_DWORD, "updated row word");
      do_correct(a, rand_word());   // Reads outside a correction leave the LRU alone
      do_read(c, SIZE_WORD, "row word c during correction", 1'b1);
      do_correct(b, rand_word());   // Hit on row 0 above sends this one to row 1
      do_read(a, SIZE_WORD, "word a evicted again");
      do_idle();
      report_test("LRU replacement and write update", errs);
   endtask

   //********************
   // Sequence and watchdog
   //********************
   initial begin
      seed    = 32'hecae;
      reset   = 1'b1;
      req     = '0;
      rw_addr = '0;
      fix     = '0;
      repeat (RESET_CYCLES) @(negedge clk);
      reset = 1'b0;
      test_dword_rw();
      test_word_banks();
      test_half_read();
      test_correction();
      test_lru();
      $display("Tests passed: %0d, failed: %0d", pass_count, fail_count);
      if (fail_count == 0 && err_count == 0) begin
         $display("TEST OK");
      end else begin
         $display("TEST FAILED");
      end
      $finish;
   end

   initial begin
      #(TEST_CYCLES * CLK_PERIOD + MARGIN);
      $display("Timeout: the tests did not finish within %0d time units",
               TEST_CYCLES * CLK_PERIOD + MARGIN);
      $display("TEST FAILED");
      $finish;
   end

endmodule

// File: compile.f
+incdir+.
iccm_pkg.sv
iccm_bank_decode.sv
iccm_bank_ram.sv
iccm_redundancy.sv
iccm_read_align.sv
iccm_mem.sv
tb_clock_gen.sv
iccm_mem_tb.sv

// File: Makefile
SIM := obj_dir/Viccm_mem_tb

.PHONY: all run clean

all: run

$(SIM): compile.f $(wildcard *.sv *.svh)
	verilator --binary --timing --top-module iccm_mem_tb -f compile.f

run: $(SIM)
	./$(SIM) | tee sim.log
	grep -q "^TEST OK$$" sim.log

clean:
	rm -rf obj_dir sim.log
